// ==== hdl/gsharePkg.sv ====
// Gshare predictor definitions
package gsharePkg;

  // fetch PC width and the byte offset of a 4-byte instruction
  localparam int SIZE_PC = 32;
  localparam int INST_BYTE_OFFSET = 2;

  // four instructions are fetched per cycle
  // each slot of an aligned bundle maps to its own counter bank
  localparam int FETCH_WIDTH_LOG = 2;
  localparam int FETCH_WIDTH = 1 << FETCH_WIDTH_LOG;

  // the full counter index covers all banks together
  localparam int CNT_TBL_LOG = 10;

  // row index inside one bank, after the bank bits are taken off
  localparam int BANK_INDEX = CNT_TBL_LOG - FETCH_WIDTH_LOG;
  localparam int BANK_DEPTH = 1 << BANK_INDEX;

  // the history holds enough bits for one row plus the bits that slot 0 skips,
  // so every slot in the bundle sees a full row-wide window
  localparam int BHR_WIDTH = BANK_INDEX + FETCH_WIDTH;

  // 2-bit saturating counter whose values 2 and 3 predict taken
  typedef logic [1:0] counterT;

  // every counter starts out weakly not taken
  localparam counterT COUNTER_RESET = 2'd1;

  // bank and row pair inside the counter index
  // the bank sits in the upper bits so the flat word reads as {bank, row}
  typedef struct packed {
    logic [FETCH_WIDTH_LOG-1:0] bank;
    logic [BANK_INDEX-1:0]      row;
  } phtFieldsT;

  // counter index as seen by the core and as seen by the banks
  // the core stores the flat word with the branch and hands it back at commit,
  // while the predictor splits it into bank and row
  typedef union packed {
    logic [CNT_TBL_LOG-1:0] flat;
    phtFieldsT              fields;
  } phtIndexT;

endpackage

// ==== hdl/counterBank.sv ====
// Counter bank
`timescale 1ns/1ps

module counterBank
  import gsharePkg::*;
#(
  parameter int DEPTH = 256
)
(
  input  logic                     clk,
  input  logic                     reset,

  // prediction read port, answered in the same cycle
  input  logic [$clog2(DEPTH)-1:0] rdRow_i,
  output counterT                  rdData_o,

  // commit write port
  input  logic [$clog2(DEPTH)-1:0] wrRow_i,
  input  counterT                  wrData_i,
  input  logic                     wrEn_i
);

  // one counter per row of this bank
  counterT counters [0:DEPTH-1];

  // reset puts every counter to weakly not taken
  // otherwise a commit write lands at the edge and is visible next cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        counters[i] <= COUNTER_RESET;
      end
    end
    else if (wrEn_i)
    begin
      counters[wrRow_i] <= wrData_i;
    end
  end

  // the read is asynchronous so prediction stays combinational from the PC
  assign rdData_o = counters[rdRow_i];

endmodule

// ==== hdl/branchHistory.sv ====
// Branch history registers
`timescale 1ns/1ps

module branchHistory
  import gsharePkg::*;
(
  input  logic                   clk,
  input  logic                   reset,

  // directions predicted this cycle, one bit per slot
  input  logic [FETCH_WIDTH-1:0] predDir_i,
  // conditional branch slots of the previous cycle's bundle
  input  logic [FETCH_WIDTH-1:0] specBHRCtrlVect_i,

  input  logic                   recoverFlag_i,
  input  logic                   fs2RecoverFlag_i,

  // committed branch outcome
  input  logic                   updateEn_i,
  input  logic                   updateDir_i,

  output logic [BHR_WIDTH-1:0]   specHistory_o
);

  // directions of the previous bundle, lined up with the control vector
  logic [FETCH_WIDTH-1:0] predDirReg;

  // speculative history used for indexing and the committed history for recovery
  logic [BHR_WIDTH-1:0]   specHistory;
  logic [BHR_WIDTH-1:0]   archHistory;

  // spec history after the flagged directions are shifted in
  logic [BHR_WIDTH-1:0]   specHistoryNext;

  // which slots hold branches is only known a cycle later,
  // so the predicted directions wait one cycle here
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      predDirReg <= {FETCH_WIDTH{1'b1}};
    end
    else
    begin
      predDirReg <= predDir_i;
    end
  end

  // compact the flagged directions into the history
  // walking the slots in order shifts the lowest flagged slot in first,
  // so the last flagged slot ends up in bit 0
  // unflagged slots leave the history untouched
  always_comb
  begin
    specHistoryNext = specHistory;
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      if (specBHRCtrlVect_i[i])
      begin
        specHistoryNext = {specHistoryNext[BHR_WIDTH-2:0], predDirReg[i]};
      end
    end
  end

  // a full recovery wins over everything and restores the committed history
  // a fetch-stage-2 recovery only freezes the spec history for that cycle
  // the committed history shifts at commit unless a recovery is under way
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      specHistory <= {BHR_WIDTH{1'b1}};
      archHistory <= {BHR_WIDTH{1'b1}};
    end
    else
    begin
      if (recoverFlag_i)
      begin
        specHistory <= archHistory;
      end
      else if (!fs2RecoverFlag_i)
      begin
        specHistory <= specHistoryNext;
      end

      if (updateEn_i && !recoverFlag_i)
      begin
        archHistory <= {archHistory[BHR_WIDTH-2:0], updateDir_i};
      end
    end
  end

  assign specHistory_o = specHistory;

endmodule

// ==== hdl/indexHash.sv ====
// Gshare index hash
`timescale 1ns/1ps

module indexHash
  import gsharePkg::*;
(
  input  logic [SIZE_PC-1:0]   PC_i,
  input  logic [BHR_WIDTH-1:0] specHistory_i,

  // bank and row of the counter for every slot
  output phtIndexT             slotIndex_o [0:FETCH_WIDTH-1]
);

  // history with its bit order reversed
  logic [BHR_WIDTH-1:0] historyFlipped;

  // reversing the history puts the oldest bits against the low address bits,
  // so the most significant part of each operand meets the least significant of the other
  always_comb
  begin
    for (int j = 0; j < BHR_WIDTH; j++)
    begin
      historyFlipped[j] = specHistory_i[BHR_WIDTH-1-j];
    end
  end

  // per slot the word address is the fetch PC plus the slot number
  // its low bits choose the bank and the next bits form the instruction index
  always_comb
  begin
    logic [SIZE_PC-INST_BYTE_OFFSET-1:0] wordAddr;
    logic [BANK_INDEX-1:0]               window;

    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      wordAddr = PC_i[SIZE_PC-1:INST_BYTE_OFFSET] + (SIZE_PC - INST_BYTE_OFFSET)'(i);

      // slot i looks at flipped bits 1+i up to 8+i
      // the window slides by one bit per slot so each later slot sees one more history bit
      window = historyFlipped[BANK_INDEX+i -: BANK_INDEX];

      // the flat word is {bank, instIndex} with the window folded into the row part only
      slotIndex_o[i].flat =
        {wordAddr[FETCH_WIDTH_LOG-1:0], wordAddr[CNT_TBL_LOG-1:FETCH_WIDTH_LOG]} ^
        {{FETCH_WIDTH_LOG{1'b0}}, window};
    end
  end

endmodule

// ==== hdl/bankRotator.sv ====
// Bank address and data rotation
`timescale 1ns/1ps

module bankRotator
  import gsharePkg::*;
(
  input  phtIndexT               slotIndex_i [0:FETCH_WIDTH-1],

  // read rows sent to the banks and the counters they return
  output logic [BANK_INDEX-1:0]  bankRow_o [0:FETCH_WIDTH-1],
  input  counterT                bankData_i [0:FETCH_WIDTH-1],

  // counters and directions in slot order
  output counterT                predCounter_o [0:FETCH_WIDTH-1],
  output logic [FETCH_WIDTH-1:0] predDir_o
);

  // bank of slot 0, which fixes where the bundle starts among the banks
  logic [FETCH_WIDTH_LOG-1:0] bundleOffset;

  assign bundleOffset = slotIndex_i[0].fields.bank;

  // consecutive slots fall into consecutive banks, wrapping around,
  // so bank b serves the slot that lies b minus the offset past slot 0
  always_comb
  begin
    logic [FETCH_WIDTH_LOG-1:0] slotSel;

    for (int b = 0; b < FETCH_WIDTH; b++)
    begin
      slotSel = FETCH_WIDTH_LOG'(b) - bundleOffset;
      bankRow_o[b] = slotIndex_i[slotSel].fields.row;
    end
  end

  // rotate the bank outputs back into slot order
  // slot s was steered to the bank the offset plus s away from bank 0
  always_comb
  begin
    logic [FETCH_WIDTH_LOG-1:0] bankSel;

    for (int s = 0; s < FETCH_WIDTH; s++)
    begin
      bankSel = bundleOffset + FETCH_WIDTH_LOG'(s);
      predCounter_o[s] = bankData_i[bankSel];

      // the upper counter bit is set for 2 and 3, which predict taken
      predDir_o[s] = predCounter_o[s][1];
    end
  end

endmodule

// ==== hdl/counterUpdate.sv ====
// Commit counter update
`timescale 1ns/1ps

module counterUpdate
  import gsharePkg::*;
(
  // index, outcome and counter the branch carried through the pipeline
  input  phtIndexT               updateIndex_i,
  input  logic                   updateDir_i,
  input  counterT                updateCounter_i,
  input  logic                   updateEn_i,

  // shared write row and data, with one write enable per bank
  output logic [BANK_INDEX-1:0]  wrRow_o,
  output counterT                wrData_o,
  output logic [FETCH_WIDTH-1:0] wrEn_o
);

  // step the counter returned at commit toward the real outcome
  // it saturates at 3 going up and at 0 going down
  always_comb
  begin
    if (updateDir_i)
    begin
      wrData_o = (updateCounter_i == 2'd3) ? updateCounter_i : updateCounter_i + 2'd1;
    end
    else
    begin
      wrData_o = (updateCounter_i == 2'd0) ? updateCounter_i : updateCounter_i - 2'd1;
    end
  end

  assign wrRow_o = updateIndex_i.fields.row;

  // only the bank named in the index is written
  always_comb
  begin
    for (int b = 0; b < FETCH_WIDTH; b++)
    begin
      wrEn_o[b] = updateEn_i && (updateIndex_i.fields.bank == FETCH_WIDTH_LOG'(b));
    end
  end

endmodule

// ==== hdl/gsharePredictor.sv ====
// Gshare branch predictor
`timescale 1ns/1ps

module gsharePredictor
  import gsharePkg::*;
(
  input  logic                   clk,
  input  logic                   reset,

  // fetch address of the current bundle
  input  logic [SIZE_PC-1:0]     PC_i,
  // branch slots of the previous cycle's bundle
  input  logic [FETCH_WIDTH-1:0] specBHRCtrlVect_i,

  input  logic                   recoverFlag_i,
  input  logic                   fs2RecoverFlag_i,

  // commit update
  input  phtIndexT               updateIndex_i,
  input  logic                   updateDir_i,
  input  counterT                updateCounter_i,
  input  logic                   updateEn_i,

  // per-slot prediction, available in the same cycle as the PC
  output logic [FETCH_WIDTH-1:0] predDir_o,
  output counterT                predCounter_o [0:FETCH_WIDTH-1],
  output phtIndexT               predIndex_o [0:FETCH_WIDTH-1]
);

  logic [BHR_WIDTH-1:0]   specHistory;

  // rotated read rows and the raw bank outputs
  logic [BANK_INDEX-1:0]  bankRow [0:FETCH_WIDTH-1];
  counterT                bankData [0:FETCH_WIDTH-1];

  // commit write shared by all banks, enabled for one of them
  logic [BANK_INDEX-1:0]  wrRow;
  counterT                wrData;
  logic [FETCH_WIDTH-1:0] wrEn;

  // the slot indices go out to the core and also drive the bank rotation
  indexHash indexHash_i (
    .PC_i          (PC_i),
    .specHistory_i (specHistory),
    .slotIndex_o   (predIndex_o)
  );

  bankRotator bankRotator_i (
    .slotIndex_i   (predIndex_o),
    .bankRow_o     (bankRow),
    .bankData_i    (bankData),
    .predCounter_o (predCounter_o),
    .predDir_o     (predDir_o)
  );

  // one bank per slot position
  for (genvar g = 0; g < FETCH_WIDTH; g++)
  begin : bankGen
    counterBank #(
      .DEPTH (BANK_DEPTH)
    ) counterBank_i (
      .clk      (clk),
      .reset    (reset),
      .rdRow_i  (bankRow[g]),
      .rdData_o (bankData[g]),
      .wrRow_i  (wrRow),
      .wrData_i (wrData),
      .wrEn_i   (wrEn[g])
    );
  end

  // the predicted directions feed back into the history a cycle later
  branchHistory branchHistory_i (
    .clk               (clk),
    .reset             (reset),
    .predDir_i         (predDir_o),
    .specBHRCtrlVect_i (specBHRCtrlVect_i),
    .recoverFlag_i     (recoverFlag_i),
    .fs2RecoverFlag_i  (fs2RecoverFlag_i),
    .updateEn_i        (updateEn_i),
    .updateDir_i       (updateDir_i),
    .specHistory_o     (specHistory)
  );

  counterUpdate counterUpdate_i (
    .updateIndex_i   (updateIndex_i),
    .updateDir_i     (updateDir_i),
    .updateCounter_i (updateCounter_i),
    .updateEn_i      (updateEn_i),
    .wrRow_o         (wrRow),
    .wrData_o        (wrData),
    .wrEn_o          (wrEn)
  );

endmodule

// ==== verification/gsharePredictorTb.sv ====
// Gshare predictor testbench
`timescale 1ns/1ps

module gsharePredictorTb
  import gsharePkg::*;
();

  // room for vectors and a bound on the lines the reader may walk through
  localparam int MAX_LINES = 64;
  localparam int READ_LIMIT = 256;
  localparam string GOLDEN_PATH = "verification/gshareGolden.txt";

  // one golden line holds the stimulus columns first and the expected values after them
  localparam int FIELD_COUNT = 17;
  localparam int EXP_DIR = 8;
  localparam int EXP_CNT = 9;
  localparam int EXP_IDX = 13;

  logic                   clk;
  logic                   reset;
  logic [SIZE_PC-1:0]     pc;
  logic [FETCH_WIDTH-1:0] ctrlVect;
  logic                   recoverFlag;
  logic                   fs2RecoverFlag;
  phtIndexT               updateIndex;
  logic                   updateDir;
  counterT                updateCounter;
  logic                   updateEn;

  logic [FETCH_WIDTH-1:0] predDir;
  counterT                predCounter [0:FETCH_WIDTH-1];
  phtIndexT               predIndex [0:FETCH_WIDTH-1];

  // every golden line is kept as raw 32-bit words with one word per column
  logic [31:0]            golden [0:MAX_LINES-1][0:FIELD_COUNT-1];
  int                     lineCount;

  gsharePredictor gsharePredictor_i (
    .clk               (clk),
    .reset             (reset),
    .PC_i              (pc),
    .specBHRCtrlVect_i (ctrlVect),
    .recoverFlag_i     (recoverFlag),
    .fs2RecoverFlag_i  (fs2RecoverFlag),
    .updateIndex_i     (updateIndex),
    .updateDir_i       (updateDir),
    .updateCounter_i   (updateCounter),
    .updateEn_i        (updateEn),
    .predDir_o         (predDir),
    .predCounter_o     (predCounter),
    .predIndex_o       (predIndex)
  );

  // 20 ns clock period
  always
  begin
    #10 clk = ~clk;
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compareValue(input string name, input int vector,
                              input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected)
    begin
      failRun($sformatf("mismatch %s at vector %0d: got 0x%0h, expected 0x%0h",
                        name, vector, actual, expected));
    end
  endtask

  // comment lines start with two slashes and blank lines carry no vector
  task automatic readGolden();
    int          fd;
    int          code;
    int          guard;
    string       text;
    logic [31:0] f [0:FIELD_COUNT-1];

    fd = $fopen(GOLDEN_PATH, "r");
    if (fd == 0)
    begin
      failRun("could not open the golden file verification/gshareGolden.txt");
    end
    lineCount = 0;
    guard = 0;
    while (!$feof(fd) && guard < READ_LIMIT)
    begin
      guard++;
      code = $fgets(text, fd);
      if (code > 0 && text.substr(0, 1) != "//")
      begin
        code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                       f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
        if (code > 0 && code != FIELD_COUNT)
        begin
          failRun($sformatf("golden line %0d has %0d columns instead of 17", guard, code));
        end
        if (code == FIELD_COUNT)
        begin
          if (lineCount >= MAX_LINES)
          begin
            failRun("the golden file holds more vectors than the testbench can store");
          end
          for (int k = 0; k < FIELD_COUNT; k++)
          begin
            golden[lineCount][k] = f[k];
          end
          lineCount++;
        end
      end
    end
    if (!$feof(fd))
    begin
      failRun("reading the golden file timed out before the end of the file");
    end
    $fclose(fd);
    if (lineCount == 0)
    begin
      failRun("the golden file holds no vectors");
    end
  endtask

  // stimulus columns are cut down to the width of each DUT input
  task automatic applyVector(input int n);
    pc = golden[n][0];
    ctrlVect = golden[n][1][FETCH_WIDTH-1:0];
    recoverFlag = golden[n][2][0];
    fs2RecoverFlag = golden[n][3][0];
    updateIndex.flat = golden[n][4][CNT_TBL_LOG-1:0];
    updateDir = golden[n][5][0];
    updateCounter = golden[n][6][1:0];
    updateEn = golden[n][7][0];
  endtask

  task automatic checkVector(input int n);
    compareValue("predDir_o", n, 32'(predDir), golden[n][EXP_DIR]);
    for (int s = 0; s < FETCH_WIDTH; s++)
    begin
      compareValue($sformatf("predCounter_o[%0d]", s), n, 32'(predCounter[s]),
                   golden[n][EXP_CNT+s]);
      compareValue($sformatf("predIndex_o[%0d]", s), n, 32'(predIndex[s].flat),
                   golden[n][EXP_IDX+s]);
    end
  endtask

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    pc = '0;
    ctrlVect = '0;
    recoverFlag = 1'b0;
    fs2RecoverFlag = 1'b0;
    updateIndex.flat = '0;
    updateDir = 1'b0;
    updateCounter = '0;
    updateEn = 1'b0;

    readGolden();

    // reset covers three rising edges and drops just after the third one
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // each vector is driven 1 ns after an edge and checked 2 ns before the next one,
    // when the combinational prediction has settled
    for (int n = 0; n < lineCount; n++)
    begin
      applyVector(n);
      #17;
      checkVector(n);
      @(posedge clk);
      #1;
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== verification/gshareGolden.txt ====
// columns in hex: pc ctrl rec fs2 updIdx updDir updCnt updEn
//   then expDir expCnt0 expCnt1 expCnt2 expCnt3 expIdx0 expIdx1 expIdx2 expIdx3
// after reset with all-ones history
00000000 0 0 0 000 0 0 0 0 1 1 1 1 0ff 1ff 2ff 3ff
// commit writes, saturating up at 3 and down at 0
00000000 0 0 0 0ff 1 1 1 0 1 1 1 1 0ff 1ff 2ff 3ff
00000000 0 0 0 1ff 1 3 1 1 2 1 1 1 0ff 1ff 2ff 3ff
00000000 0 0 0 2ff 0 0 1 3 2 3 1 1 0ff 1ff 2ff 3ff
00000000 0 0 0 0fe 1 2 1 3 2 3 0 1 0ff 1ff 2ff 3ff
00000000 0 0 0 1fe 1 1 1 3 2 3 0 1 0ff 1ff 2ff 3ff
// bundle starting at bank 2
00000008 0 0 0 000 0 0 0 c 0 1 3 2 2ff 3ff 0fe 1fe
// slots 1 and 3 of the previous bundle shift into the history
00000000 a 0 0 000 0 0 0 3 2 3 0 1 0ff 1ff 2ff 3ff
00000000 0 0 0 000 0 0 0 3 2 3 1 1 0ff 1ff 27f 3bf
// fetch-stage-2 recovery holds, full recovery loads the committed history
00000000 f 0 1 000 0 0 0 3 2 3 1 1 0ff 1ff 27f 3bf
00000000 f 1 0 000 0 0 0 3 2 3 1 1 0ff 1ff 27f 3bf
00000000 0 0 0 000 0 0 0 1 2 1 1 1 0ff 17f 2bf 3df
00000008 0 0 0 000 0 0 0 0 0 1 1 1 2ff 37f 0be 1de
00000404 0 0 0 000 0 0 0 0 1 1 1 1 1bf 23f 3ff 09e

// ==== build.f ====
hdl/gsharePkg.sv
hdl/counterBank.sv
hdl/branchHistory.sv
hdl/indexHash.sv
hdl/bankRotator.sv
hdl/counterUpdate.sv
hdl/gsharePredictor.sv
verification/gsharePredictorTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the gshare predictor testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --top-module gsharePredictorTb -f build.f \
  -Mdir obj_dir -o gsharePredictorSim > "$BUILD_LOG" 2>&1
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator compile failed with status $buildStatus"
  exit 1
fi

./obj_dir/gsharePredictorSim > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q '^>>> PASS$' "$SIM_LOG"; then
  exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
